//--- qpu_exu_top.f
+incdir+.
qpu_pkg.sv
qpu_exu_decode.sv
qpu_exu_disp.sv
qpu_exu_oitf.sv
qpu_exu_alu.sv
qpu_exu_regfile.sv
qpu_exu_top.sv
tb_clk_gen.sv
tb_qpu_exu.sv

//--- Bender.yml
package:
  name: qpu_exu

sources:
  - include_dirs:
      - .
    files:
      - qpu_pkg.sv
      - qpu_exu_decode.sv
      - qpu_exu_disp.sv
      - qpu_exu_oitf.sv
      - qpu_exu_alu.sv
      - qpu_exu_regfile.sv
      - qpu_exu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_qpu_exu.sv

//--- qpu_exu_cases.txt
# I <instruction word> <expected commit data>
# E <timestamp> <gate> <mask> after QOP and MEASURE, M <returned values> after MEASURE
I 1080000f 0000000f
I 32880000 00000000
I 08800064 00000064
I 09087fff 00008063
I 01890000 000080c7
I 01998000 0001018e
I 08180005 00010193
I 02018000 0001018e
I 18000014 00000014
I 11000030 00000030
I 20080012 00000000
E 0014 12 0f
I 18007fff 00008013
I 201000a5 00000000
E 8013 a5 30
I 18007fff 00000012
I 1100000c 0000000c
I 20100001 00000000
E 0012 01 0c
I 28080000 00000000
E 0012 ff 0f
M a6
I 33080000 00000006
I 33900000 00000004
I 118000f0 000000f0
I 28180000 00000000
E 0012 ff f0
M 5b
I 18000003 00000015
I 20080033 00000000
E 0015 33 0f
I 34180000 00000050
I 04c30000 00000056
I 0d380001 00000005

//--- tb_qpu_exu.sv
`default_nettype none

`include "qpu_consts.svh"

module tb_qpu_exu
  import qpu_pkg::*;
();

  logic        clk;
  logic        i_reset;
  logic        i_instr_valid;
  logic        o_instr_ready;
  logic [31:0] i_instr;
  logic        o_event_valid;
  logic        i_event_ready;
  event_t      o_event;
  logic        o_cmt_valid;
  cmt_t        o_cmt;
  logic        i_meas_valid;
  meas_t       i_meas;

  integer seed = 32'hc6d8_5987;
  logic   load_done = 1'b0;
  logic   run_active = 1'b0;
  int     cm_idx = 0;
  int     ev_idx = 0;
  int     meas_sent = 0;
  int     meas_returned = 0;

  // expected stream, built by the model while the cases file is read
  logic [31:0] exp_instr [$];
  xlen_t       exp_data [$];
  int          exp_req [$];
  qtime_t      ev_time [$];
  gate_t       ev_gate [$];
  qmask_t      ev_mask [$];
  logic        ev_is_meas [$];
  qmask_t      meas_qubits [$];
  qmask_t      meas_values [$];

  // architectural state of the reference model
  xlen_t  m_cls [`QPU_RF_NUM];
  qmask_t m_msk [`QPU_RF_NUM];
  qtime_t m_time;
  qmask_t m_meas;

  tb_clk_gen clk_gen_i (.o_clk(clk));

  qpu_exu_top dut_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_event_valid (o_event_valid),
    .i_event_ready (i_event_ready),
    .o_event       (o_event),
    .o_cmt_valid   (o_cmt_valid),
    .o_cmt         (o_cmt),
    .i_meas_valid  (i_meas_valid),
    .i_meas        (i_meas)
  );

  //////////////////////////////////////////////////////////////////////////////
  // checking helpers

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp)
    begin
      stop_on_error($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                              $time, name, act, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // reference model, one instruction at a time in program order

  task automatic model_instr(input logic [31:0] word, input logic [31:0] file_data);
    opcode_e op;
    rfidx_t  rd;
    rfidx_t  rs1;
    rfidx_t  rs2;
    xlen_t   imm;
    xlen_t   data;
    int      req;
    op   = opcode_e'(word[31:27]);
    rd   = word[26:23];
    rs1  = word[22:19];
    rs2  = word[18:15];
    imm  = {17'b0, word[14:0]};
    data = '0;
    req  = 0;
    case (op)
      OP_ADD:  data = m_cls[rs1] + m_cls[rs2];
      OP_ADDI: data = m_cls[rs1] + imm;
      OP_SMIS:
      begin
        m_msk[rd] = imm[7:0];
        data      = {24'b0, imm[7:0]};
      end
      OP_QWAIT:
      begin
        m_time = m_time + imm[15:0];
        data   = {16'b0, m_time};
      end
      OP_QOP, OP_MEASURE:
      begin
        ev_time.push_back(m_time);
        ev_gate.push_back((op == OP_MEASURE) ? `QPU_MEASURE_GATE : imm[7:0]);
        ev_mask.push_back(m_msk[rs1]);
        ev_is_meas.push_back(op == OP_MEASURE);
        if (op == OP_MEASURE)
        begin
          meas_qubits.push_back(m_msk[rs1]);
        end
      end
      OP_FMR:
      begin
        data = {24'b0, m_meas & m_msk[rs1]};
        // must follow the return of the last overlapping measure
        for (int k = 0; k < meas_qubits.size(); k++)
        begin
          if (|(meas_qubits[k] & m_msk[rs1]))
          begin
            req = k + 1;
          end
        end
      end
      default: stop_on_error("Unknown opcode in the cases file");
    endcase
    if (((op == OP_ADD) || (op == OP_ADDI) || (op == OP_FMR)) && (rd != 0))
    begin
      m_cls[rd] = data;
    end
    check_value("cases file commit data", file_data, data);
    exp_instr.push_back(word);
    exp_data.push_back(data);
    exp_req.push_back(req);
  endtask

  task automatic load_cases();
    int               fd;
    int               n;
    int               idx;
    logic [15:0]      kind;
    logic [8*128-1:0] rest;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    for (int i = 0; i < `QPU_RF_NUM; i++)
    begin
      m_cls[i] = '0;
      m_msk[i] = '0;
    end
    m_time = '0;
    m_meas = '0;
    idx    = 0;
    fd = $fopen("qpu_exu_cases.txt", "r");
    if (fd == 0)
    begin
      stop_on_error("Cannot open the cases file qpu_exu_cases.txt");
    end
    while ($fscanf(fd, "%s", kind) == 1)
    begin
      if (kind == "#")
      begin
        n = $fgets(rest, fd);
      end
      else if (kind == "I")
      begin
        n = $fscanf(fd, "%h %h", a, b);
        if (n != 2)
        begin
          stop_on_error("Cases file has an instruction line with missing fields");
        end
        model_instr(a, b);
      end
      else if ((kind == "E") && (idx < ev_time.size()))
      begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        if (n != 3)
        begin
          stop_on_error("Cases file has an event line with missing fields");
        end
        check_value("cases file event timestamp", a, ev_time[idx]);
        check_value("cases file event gate", b, ev_gate[idx]);
        check_value("cases file event mask", c, ev_mask[idx]);
        idx = idx + 1;
      end
      else if ((kind == "M") && (meas_values.size() < meas_qubits.size()))
      begin
        n = $fscanf(fd, "%h", a);
        if (n != 1)
        begin
          stop_on_error("Cases file has a measure line without a value");
        end
        meas_values.push_back(a[7:0]);
        m_meas = (m_meas & ~meas_qubits[$]) | (a[7:0] & meas_qubits[$]);
      end
      else
      begin
        stop_on_error("Cases file has a line that does not fit the instruction stream");
      end
    end
    $fclose(fd);
    check_value("cases file event lines", idx, ev_time.size());
    check_value("cases file measure lines", meas_values.size(), meas_qubits.size());
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // output monitors, sampled at the falling edge

  task automatic check_event();
    if (ev_idx >= ev_time.size())
    begin
      stop_on_error("The DUT sent more events than the program has");
    end
    else
    begin
      check_value("o_event.tstamp", o_event.tstamp, ev_time[ev_idx]);
      check_value("o_event.gate", o_event.gate, ev_gate[ev_idx]);
      check_value("o_event.mask", o_event.mask, ev_mask[ev_idx]);
      if (ev_is_meas[ev_idx])
      begin
        meas_sent = meas_sent + 1;
      end
      ev_idx = ev_idx + 1;
    end
  endtask

  task automatic check_commit();
    opcode_e op;
    logic    exp_rd_wen;
    logic    exp_mask_wen;
    if (cm_idx >= exp_instr.size())
    begin
      stop_on_error("The DUT committed more instructions than the program has");
    end
    else
    begin
      op           = opcode_e'(exp_instr[cm_idx][31:27]);
      exp_rd_wen   = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_FMR);
      exp_mask_wen = (op == OP_SMIS);
      check_value("o_cmt.op", o_cmt.op, op);
      check_value("o_cmt.rd", o_cmt.rd, exp_instr[cm_idx][26:23]);
      check_value("o_cmt.rd_wen", o_cmt.rd_wen, exp_rd_wen);
      check_value("o_cmt.mask_wen", o_cmt.mask_wen, exp_mask_wen);
      check_value("o_cmt.data", o_cmt.data, exp_data[cm_idx]);
      if ((op == OP_QOP) || (op == OP_MEASURE))
      begin
        check_value("event transfer in commit cycle", o_event_valid && i_event_ready, 1);
      end
      if (op == OP_FMR)
      begin
        check_value("measure returns before FMR commit", meas_returned >= exp_req[cm_idx], 1);
      end
      cm_idx = cm_idx + 1;
    end
  endtask

  always @(negedge clk)
  begin
    if (run_active)
    begin
      if (o_event_valid && i_event_ready)
      begin
        check_event();
      end
      if (o_cmt_valid)
      begin
        check_commit();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // environment: event back-pressure and measurement returns

  always @(posedge clk)
  begin
    if (i_reset)
    begin
      i_event_ready <= 1'b0;
    end
    else
    begin
      // ready about three cycles in four
      i_event_ready <= (({$random(seed)} % 4) != 0);
    end
  end

  // returns go back in measure order
  initial
  begin : meas_return
    int delay;
    wait (load_done);
    for (int k = 0; k < meas_qubits.size(); k++)
    begin
      wait (meas_sent > k);
      delay = 2 + ({$random(seed)} % 19);
      @(posedge clk);
      repeat (delay) @(posedge clk);
      i_meas_valid  <= 1'b1;
      i_meas.qubits <= meas_qubits[k];
      i_meas.values <= meas_values[k];
      @(posedge clk);
      // the DUT takes the return at this edge
      meas_returned = meas_returned + 1;
      i_meas_valid  <= 1'b0;
    end
  end

  initial
  begin : watchdog
    wait (load_done);
    repeat (16 + 40 * exp_instr.size()) @(posedge clk);
    stop_on_error("Timeout: the DUT did not retire every instruction in time");
  end

  //////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    i_reset       = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_event_ready = 1'b0;
    i_meas_valid  = 1'b0;
    i_meas        = '0;
    load_cases();
    load_done = 1'b1;

    repeat (15)
    begin
      @(posedge clk);
      @(negedge clk);
      check_value("o_cmt_valid", o_cmt_valid, 0);
      check_value("o_event_valid", o_event_valid, 0);
    end
    @(posedge clk);
    i_reset    <= 1'b0;
    run_active = 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_value("o_cmt_valid", o_cmt_valid, 0);
    check_value("o_event_valid", o_event_valid, 0);

    @(posedge clk);
    for (int i = 0; i < exp_instr.size(); i++)
    begin
      i_instr_valid <= 1'b1;
      i_instr       <= exp_instr[i];
      @(negedge clk);
      while (!o_instr_ready)
      begin
        @(negedge clk);
      end
      @(posedge clk);
    end
    i_instr_valid <= 1'b0;
    i_instr       <= '0;

    wait (cm_idx == exp_instr.size());
    // idle tail so late extra commits or events get caught
    repeat (8) @(negedge clk);
    check_value("event count", ev_idx, ev_time.size());
    check_value("measure return count", meas_returned, meas_qubits.size());

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

// free running clock, period 10
module tb_clk_gen
(
  output logic o_clk
);

  initial
  begin
    o_clk = 1'b0;
    forever
    begin
      #5 o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

//--- qpu_exu_top.sv
`default_nettype none

module qpu_exu_top
(
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_instr_valid,
  output logic            o_instr_ready,
  input  logic [31:0]     i_instr,
  output logic            o_event_valid,
  input  logic            i_event_ready,
  output qpu_pkg::event_t o_event,
  output logic            o_cmt_valid,
  output qpu_pkg::cmt_t   o_cmt,
  input  logic            i_meas_valid,
  input  qpu_pkg::meas_t  i_meas
);

  ////////////////////////////////////////////////////////////////////////////
  // stage links

  logic             dec_valid;
  logic             dec_ready;
  qpu_pkg::dec_t    dec;
  logic             disp_valid;
  logic             disp_ready;
  qpu_pkg::disp_t   disp;

  // operand reads and scoreboard
  qpu_pkg::rfidx_t  rs1_idx;
  qpu_pkg::rfidx_t  rs2_idx;
  qpu_pkg::xlen_t   rs1;
  qpu_pkg::xlen_t   rs2;
  qpu_pkg::qmask_t  mask;
  qpu_pkg::qmask_t  meas_values;
  logic             hazard;
  logic             issue;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline

  qpu_exu_decode decode_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_dec_valid   (dec_valid),
    .i_dec_ready   (dec_ready),
    .o_dec         (dec)
  );

  qpu_exu_disp disp_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_dec_valid   (dec_valid),
    .o_dec_ready   (dec_ready),
    .i_dec         (dec),
    .o_rs1_idx     (rs1_idx),
    .o_rs2_idx     (rs2_idx),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_mask        (mask),
    .i_meas_values (meas_values),
    .i_hazard      (hazard),
    .o_issue       (issue),
    .o_disp_valid  (disp_valid),
    .i_disp_ready  (disp_ready),
    .o_disp        (disp)
  );

  // every issued op holds a slot until it commits
  qpu_exu_oitf oitf_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_issue      (issue),
    .i_dec        (dec),
    .i_mask       (mask),
    .i_retire     (o_cmt_valid),
    .i_meas_valid (i_meas_valid),
    .i_meas       (i_meas),
    .o_hazard     (hazard)
  );

  qpu_exu_alu alu_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_disp_valid  (disp_valid),
    .o_disp_ready  (disp_ready),
    .i_disp        (disp),
    .o_event_valid (o_event_valid),
    .i_event_ready (i_event_ready),
    .o_event       (o_event),
    .o_cmt_valid   (o_cmt_valid),
    .o_cmt         (o_cmt)
  );

  qpu_exu_regfile regfile_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_rs1_idx     (rs1_idx),
    .i_rs2_idx     (rs2_idx),
    .o_rs1         (rs1),
    .o_rs2         (rs2),
    .o_mask        (mask),
    .i_cmt_valid   (o_cmt_valid),
    .i_cmt         (o_cmt),
    .i_meas_valid  (i_meas_valid),
    .i_meas        (i_meas),
    .o_meas_values (meas_values)
  );

endmodule

`default_nettype wire

//--- qpu_exu_regfile.sv
`default_nettype none

`include "qpu_consts.svh"

module qpu_exu_regfile
  import qpu_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  input  rfidx_t i_rs1_idx,
  input  rfidx_t i_rs2_idx,
  output xlen_t  o_rs1,
  output xlen_t  o_rs2,
  output qmask_t o_mask,
  input  logic   i_cmt_valid,
  input  cmt_t   i_cmt,
  input  logic   i_meas_valid,
  input  meas_t  i_meas,
  output qmask_t o_meas_values
);

  xlen_t  cls_rf [`QPU_RF_NUM];
  qmask_t msk_rf [`QPU_RF_NUM];
  qmask_t meas_q;

  // mask read shares the rs1 index
  assign o_rs1         = cls_rf[i_rs1_idx];
  assign o_rs2         = cls_rf[i_rs2_idx];
  assign o_mask        = msk_rf[i_rs1_idx];
  assign o_meas_values = meas_q;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      for (int i = 0; i < `QPU_RF_NUM; i++)
      begin
        cls_rf[i] <= '0;
        msk_rf[i] <= '0;
      end
      meas_q <= '0;
    end
    else
    begin
      // r0 keeps its reset value of zero
      if (i_cmt_valid && i_cmt.rd_wen && (i_cmt.rd != '0))
      begin
        cls_rf[i_cmt.rd] <= i_cmt.data;
      end
      if (i_cmt_valid && i_cmt.mask_wen)
      begin
        msk_rf[i_cmt.rd] <= qmask_t'(i_cmt.data);
      end
      // only the listed qubits take new values
      if (i_meas_valid)
      begin
        meas_q <= (meas_q & ~i_meas.qubits) | (i_meas.values & i_meas.qubits);
      end
    end
  end

endmodule

`default_nettype wire

//--- qpu_exu_alu.sv
`default_nettype none

`include "qpu_consts.svh"

module qpu_exu_alu
  import qpu_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  input  logic   i_disp_valid,
  output logic   o_disp_ready,
  input  disp_t  i_disp,
  output logic   o_event_valid,
  input  logic   i_event_ready,
  output event_t o_event,
  output logic   o_cmt_valid,
  output cmt_t   o_cmt
);

  logic   out_valid;
  logic   out_is_evt;
  logic   is_evt_d;
  logic   accept;
  cmt_t   cmt_d;
  event_t evt_d;

  always_comb
  begin
    cmt_d        = '0;
    cmt_d.op     = i_disp.op;
    cmt_d.rd     = i_disp.rd;
    evt_d.tstamp = i_disp.tstamp;
    evt_d.gate   = gate_t'(i_disp.imm);
    evt_d.mask   = i_disp.mask;
    is_evt_d     = 1'b0;
    case (i_disp.op)
      OP_ADD:
      begin
        cmt_d.rd_wen = 1'b1;
        cmt_d.data   = i_disp.rs1 + i_disp.rs2;
      end
      OP_ADDI:
      begin
        cmt_d.rd_wen = 1'b1;
        cmt_d.data   = i_disp.rs1 + i_disp.imm;
      end
      OP_SMIS:
      begin
        cmt_d.mask_wen = 1'b1;
        cmt_d.data     = xlen_t'(qmask_t'(i_disp.imm));
      end
      // reports the advanced time
      OP_QWAIT:
      begin
        cmt_d.data = xlen_t'(i_disp.tstamp);
      end
      OP_QOP:
      begin
        is_evt_d = 1'b1;
      end
      OP_MEASURE:
      begin
        is_evt_d   = 1'b1;
        evt_d.gate = `QPU_MEASURE_GATE;
      end
      OP_FMR:
      begin
        cmt_d.rd_wen = 1'b1;
        cmt_d.data   = xlen_t'(i_disp.meas & i_disp.mask);
      end
      default:
      begin
        cmt_d.data = '0;
      end
    endcase
  end

  // event ops retire only in the cycle their event goes out
  assign o_event_valid = out_valid && out_is_evt;
  assign o_cmt_valid   = out_valid && (!out_is_evt || i_event_ready);
  assign o_disp_ready  = !out_valid || o_cmt_valid;
  assign accept        = i_disp_valid && o_disp_ready;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      out_valid <= 1'b0;
    end
    else if (o_disp_ready)
    begin
      out_valid <= i_disp_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      o_cmt      <= cmt_d;
      o_event    <= evt_d;
      out_is_evt <= is_evt_d;
    end
  end

endmodule

`default_nettype wire

//--- qpu_exu_oitf.sv
`default_nettype none

`include "qpu_consts.svh"

module qpu_exu_oitf
  import qpu_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  input  logic   i_issue,
  input  dec_t   i_dec,
  input  qmask_t i_mask,
  input  logic   i_retire,
  input  logic   i_meas_valid,
  input  meas_t  i_meas,
  output logic   o_hazard
);

  localparam int PTR_W = $clog2(`QPU_OITF_DEPTH);

  logic [`QPU_OITF_DEPTH-1:0] ent_vld;
  logic [`QPU_OITF_DEPTH-1:0] ent_cls;
  logic [`QPU_OITF_DEPTH-1:0] ent_msk;
  rfidx_t                     ent_idx [`QPU_OITF_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  qmask_t                     pending;
  qmask_t                     pending_nxt;
  logic                       use_rs1;
  logic                       use_rs2;
  logic                       use_mask;
  logic                       cls_hit;
  logic                       msk_hit;
  logic                       qubit_hit;

  // source usage per opcode
  assign use_rs1  = (i_dec.op == OP_ADD) || (i_dec.op == OP_ADDI);
  assign use_rs2  = (i_dec.op == OP_ADD);
  assign use_mask = (i_dec.op == OP_QOP) || (i_dec.op == OP_MEASURE) || (i_dec.op == OP_FMR);

  always_comb
  begin
    cls_hit = 1'b0;
    msk_hit = 1'b0;
    for (int i = 0; i < `QPU_OITF_DEPTH; i++)
    begin
      // r0 never blocks, it reads zero anyway
      if (ent_vld[i] && ent_cls[i] && (ent_idx[i] != '0))
      begin
        if ((use_rs1 && (ent_idx[i] == i_dec.rs1)) || (use_rs2 && (ent_idx[i] == i_dec.rs2)))
        begin
          cls_hit = 1'b1;
        end
      end
      if (ent_vld[i] && ent_msk[i] && use_mask && (ent_idx[i] == i_dec.rs1))
      begin
        msk_hit = 1'b1;
      end
    end
  end

  assign qubit_hit = (i_dec.op == OP_FMR) && |(i_mask & pending);
  assign o_hazard  = cls_hit || msk_hit || qubit_hit || ent_vld[wr_ptr];

  // a new measure wins over a return for the same qubit
  always_comb
  begin
    pending_nxt = pending;
    if (i_meas_valid)
    begin
      pending_nxt = pending_nxt & ~i_meas.qubits;
    end
    if (i_issue && (i_dec.op == OP_MEASURE))
    begin
      pending_nxt = pending_nxt | i_mask;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      ent_vld <= '0;
      ent_cls <= '0;
      ent_msk <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      pending <= '0;
      for (int i = 0; i < `QPU_OITF_DEPTH; i++)
      begin
        ent_idx[i] <= '0;
      end
    end
    else
    begin
      if (i_issue)
      begin
        ent_vld[wr_ptr] <= 1'b1;
        ent_cls[wr_ptr] <= i_dec.rd_wen;
        ent_msk[wr_ptr] <= i_dec.mask_wen;
        ent_idx[wr_ptr] <= i_dec.rd;
        wr_ptr          <= wr_ptr + 1'b1;
      end
      // commits are in order so the oldest slot retires
      if (i_retire)
      begin
        ent_vld[rd_ptr] <= 1'b0;
        rd_ptr          <= rd_ptr + 1'b1;
      end
      pending <= pending_nxt;
    end
  end

endmodule

`default_nettype wire

//--- qpu_exu_disp.sv
`default_nettype none

module qpu_exu_disp
  import qpu_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  input  logic   i_dec_valid,
  output logic   o_dec_ready,
  input  dec_t   i_dec,
  output rfidx_t o_rs1_idx,
  output rfidx_t o_rs2_idx,
  input  xlen_t  i_rs1,
  input  xlen_t  i_rs2,
  input  qmask_t i_mask,
  input  qmask_t i_meas_values,
  input  logic   i_hazard,
  output logic   o_issue,
  output logic   o_disp_valid,
  input  logic   i_disp_ready,
  output disp_t  o_disp
);

  qtime_t time_q;
  qtime_t time_nxt;

  // operand reads go straight from the decoded fields
  assign o_rs1_idx = i_dec.rs1;
  assign o_rs2_idx = i_dec.rs2;

  // qwait advances time, qop and measure just sample it
  assign time_nxt = (i_dec.op == OP_QWAIT) ? time_q + qtime_t'(i_dec.imm) : time_q;

  assign o_dec_ready = (!o_disp_valid || i_disp_ready) && !i_hazard;
  assign o_issue     = i_dec_valid && o_dec_ready;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_disp_valid <= 1'b0;
      time_q       <= '0;
    end
    else
    begin
      if (o_issue)
      begin
        o_disp_valid <= 1'b1;
        time_q       <= time_nxt;
      end
      else if (i_disp_ready)
      begin
        o_disp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (o_issue)
    begin
      o_disp.op     <= i_dec.op;
      o_disp.rd     <= i_dec.rd;
      o_disp.rs1    <= i_rs1;
      o_disp.rs2    <= i_rs2;
      o_disp.imm    <= i_dec.imm;
      o_disp.mask   <= i_mask;
      o_disp.meas   <= i_meas_values;
      o_disp.tstamp <= time_nxt;
    end
  end

endmodule

`default_nettype wire

//--- qpu_exu_decode.sv
`default_nettype none

module qpu_exu_decode
  import qpu_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  logic        i_instr_valid,
  output logic        o_instr_ready,
  input  logic [31:0] i_instr,
  output logic        o_dec_valid,
  input  logic        i_dec_ready,
  output dec_t        o_dec
);

  opcode_e op;
  dec_t    dec_d;

  assign op = opcode_e'(i_instr[31:27]);

  // field split, immediate is unsigned
  always_comb
  begin
    dec_d          = '0;
    dec_d.op       = op;
    dec_d.rd       = i_instr[26:23];
    dec_d.rs1      = i_instr[22:19];
    dec_d.rs2      = i_instr[18:15];
    dec_d.imm      = xlen_t'(i_instr[14:0]);
    dec_d.rd_wen   = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_FMR);
    dec_d.mask_wen = (op == OP_SMIS);
  end

  // single slot, refills in the cycle it drains
  assign o_instr_ready = !o_dec_valid || i_dec_ready;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_dec_valid <= 1'b0;
    end
    else if (o_instr_ready)
    begin
      o_dec_valid <= i_instr_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_instr_valid && o_instr_ready)
    begin
      o_dec <= dec_d;
    end
  end

endmodule

`default_nettype wire

//--- qpu_pkg.sv
`default_nettype none

`include "qpu_consts.svh"

package qpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic vectors

  typedef logic [`QPU_XLEN-1:0]        xlen_t;
  typedef logic [`QPU_RFIDX_WIDTH-1:0] rfidx_t;
  typedef logic [`QPU_TIME_WIDTH-1:0]  qtime_t;
  typedef logic [`QPU_QUBIT_NUM-1:0]   qmask_t;
  typedef logic [`QPU_GATE_WIDTH-1:0]  gate_t;

  // instruction bits 31:27
  typedef enum logic [4:0] {
    OP_ADD     = 5'd0,
    OP_ADDI    = 5'd1,
    OP_SMIS    = 5'd2,
    OP_QWAIT   = 5'd3,
    OP_QOP     = 5'd4,
    OP_MEASURE = 5'd5,
    OP_FMR     = 5'd6
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // stage payloads

  typedef struct packed {
    opcode_e op;
    rfidx_t  rd;
    rfidx_t  rs1;
    rfidx_t  rs2;
    xlen_t   imm;
    logic    rd_wen;
    logic    mask_wen;
  } dec_t;

  typedef struct packed {
    opcode_e op;
    rfidx_t  rd;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   imm;
    qmask_t  mask;
    qmask_t  meas;
    qtime_t  tstamp;
  } disp_t;

  typedef struct packed {
    qtime_t tstamp;
    gate_t  gate;
    qmask_t mask;
  } event_t;

  typedef struct packed {
    opcode_e op;
    rfidx_t  rd;
    logic    rd_wen;
    logic    mask_wen;
    xlen_t   data;
  } cmt_t;

  typedef struct packed {
    qmask_t qubits;
    qmask_t values;
  } meas_t;

endpackage

`default_nettype wire

//--- qpu_consts.svh
`ifndef QPU_CONSTS_SVH
`define QPU_CONSTS_SVH

// classical datapath
`define QPU_XLEN          32
`define QPU_RF_NUM        16
`define QPU_RFIDX_WIDTH   4

// timing and qubit side
`define QPU_TIME_WIDTH    16
`define QPU_QUBIT_NUM     8
`define QPU_GATE_WIDTH    8

// gate code carried by measure events
`define QPU_MEASURE_GATE  8'hff

// in-flight destination slots
`define QPU_OITF_DEPTH    4

`endif
